//--- pll_reconfig_cfg.svh
/*
 * Shared widths, slot numbers and CSR offsets for the TX PLL
 * reconfiguration register access. Include wherever a macro is needed.
 */

`ifndef PLL_RECONFIG_CFG_SVH
`define PLL_RECONFIG_CFG_SVH

// Avalon bus widths
`define AVMM_ADDR_W 12
`define AVMM_DATA_W 16

// DPRIO space layout
// Slot field sits above the register index
`define DPRIO_SLOTS 90
`define DPRIO_SLOT_LSB 4
`define DPRIO_REG_W 4

// Block slots filled by each PLL type
`define SLOT_CDR 5
`define SLOT_CDR_MUX 6
`define SLOT_ATX 83
`define SLOT_ATX_MUX 87

// Address bit 11 set means soft CSR space
`define CSR_SEL_BIT 11

// Soft CSR offsets
`define CSR_REG_TYPE 0
`define CSR_REG_STATUS 1
`define CSR_REG_CTRL 2

`endif

//--- pll_reconfig_pkg.sv
/*
 * Types shared by the reconfiguration blocks. The bus request travels as
 * one packed struct and each DPRIO block answers with a response struct.
 */

`default_nettype none

`include "pll_reconfig_cfg.svh"

package pll_reconfig_pkg;

  // PLL type as reported at CSR offset 0
  // Value 3 was the fPLL code and stays unused
  typedef enum logic [1:0] {
    NONE = 2'd0,
    CMU  = 2'd1,
    ATX  = 2'd2
  } pll_type_e;

  // Avalon request, 30 bits
  // Read and write are single-cycle strobes
  typedef struct packed {
    logic                    write;
    logic                    read;
    logic [`AVMM_ADDR_W-1:0] address;
    logic [`AVMM_DATA_W-1:0] writedata;
  } avmm_req_t;

  // Response of one DPRIO block, 17 bits
  // Readdata is zero whenever blockselect is low,
  // so responses can simply be ORed together
  typedef struct packed {
    logic                    blockselect;
    logic [`AVMM_DATA_W-1:0] readdata;
  } blk_rsp_t;

endpackage

`default_nettype wire

//--- dprio_block_regs.sv
/*
 * One DPRIO block of sixteen 16-bit registers answering a single slot.
 * A read that hits the slot returns its word and blockselect one cycle
 * later. Requests for other slots are ignored.
 */

`timescale 1ns/100ps
`default_nettype none

`include "pll_reconfig_cfg.svh"

module dprio_block_regs #(
  parameter int slot = 0
) (
  input  wire                              pld_avmm_clk,
  input  wire                              pld_avmm_reset,
  input  wire pll_reconfig_pkg::avmm_req_t dprio_req,
  output pll_reconfig_pkg::blk_rsp_t       rsp
);
  import pll_reconfig_pkg::*;

  // Slot field runs from bit 4 up to bit 10
  localparam int slot_w     = `CSR_SEL_BIT - `DPRIO_SLOT_LSB;
  localparam int reg_cnt    = 1 << `DPRIO_REG_W;
  // Out of range slot never answers
  localparam bit slot_valid = (slot >= 0) && (slot < `DPRIO_SLOTS);

  logic [slot_w-1:0]       req_slot;
  logic [`DPRIO_REG_W-1:0] req_idx;
  logic                    hit;
  logic [`AVMM_DATA_W-1:0] regs [reg_cnt];
  blk_rsp_t                rsp_next;

  assign req_slot = dprio_req.address[`DPRIO_SLOT_LSB +: slot_w];
  assign req_idx  = dprio_req.address[`DPRIO_REG_W-1:0];
  assign hit      = slot_valid && (req_slot == slot_w'(slot));

  // Register file, cleared by reset
  always_ff @(posedge pld_avmm_clk or posedge pld_avmm_reset) begin
    if (pld_avmm_reset) begin
      for (int i = 0; i < reg_cnt; i++) begin
        regs[i] <= '0;
      end
    end else if (hit && dprio_req.write) begin
      regs[req_idx] <= dprio_req.writedata;
    end
  end

  // Readdata stays zero unless this block is selected
  always_comb begin
    rsp_next.blockselect = hit & dprio_req.read;
    rsp_next.readdata    = rsp_next.blockselect ? regs[req_idx] : '0;
  end

  // One-cycle read response
  always_ff @(posedge pld_avmm_clk or posedge pld_avmm_reset) begin
    if (pld_avmm_reset) begin
      rsp <= '0;
    end else begin
      rsp <= rsp_next;
    end
  end

endmodule

`default_nettype wire

//--- pll_soft_csr.sv
/*
 * Soft CSR file of the TX PLL. Reports the PLL type and lock status,
 * keeps a sticky loss-of-lock flag and holds the PLL reset override.
 * Read data is registered and valid one cycle after the read strobe.
 */

`timescale 1ns/100ps
`default_nettype none

`include "pll_reconfig_cfg.svh"

module pll_soft_csr #(
  parameter pll_reconfig_pkg::pll_type_e pll_type = pll_reconfig_pkg::CMU
) (
  input  wire                              pld_avmm_clk,
  input  wire                              pld_avmm_reset,
  input  wire pll_reconfig_pkg::avmm_req_t csr_req,
  output logic [`AVMM_DATA_W-1:0]          csr_readdata,
  input  wire                              pll_locked,
  output logic                             pll_reset_ovr
);

  // Offset covers everything below the space select bit
  localparam int                off_w      = `CSR_SEL_BIT;
  localparam logic [off_w-1:0] reg_type   = `CSR_REG_TYPE;
  localparam logic [off_w-1:0] reg_status = `CSR_REG_STATUS;
  localparam logic [off_w-1:0] reg_ctrl   = `CSR_REG_CTRL;

  logic [off_w-1:0]        offset;
  logic [`AVMM_DATA_W-1:0] read_word;
  // Lock history for edge detect
  logic                    lock_q;
  logic                    lock_fall;
  logic                    lost_lock;
  logic                    lost_lock_clr;

  assign offset = csr_req.address[off_w-1:0];

  assign lock_fall = lock_q & ~pll_locked;
  // Write 1 to bit 1 of status
  assign lost_lock_clr = csr_req.write && (offset == reg_status) && csr_req.writedata[1];

  always_ff @(posedge pld_avmm_clk or posedge pld_avmm_reset) begin
    if (pld_avmm_reset) begin
      lock_q        <= 1'b0;
      lost_lock     <= 1'b0;
      pll_reset_ovr <= 1'b0;
    end else begin
      lock_q <= pll_locked;
      // A new loss wins over a clear in the same cycle
      if (lock_fall) begin
        lost_lock <= 1'b1;
      end else if (lost_lock_clr) begin
        lost_lock <= 1'b0;
      end
      // Control register holds only the override bit
      if (csr_req.write && (offset == reg_ctrl)) begin
        pll_reset_ovr <= csr_req.writedata[0];
      end
    end
  end

  // Read mux, unmapped offsets give zero
  always_comb begin
    read_word = '0;
    case (offset)
      reg_type:   read_word[1:0] = pll_type;
      reg_status: read_word[1:0] = {lost_lock, pll_locked};
      reg_ctrl:   read_word[0]   = pll_reset_ovr;
      default:    read_word      = '0;
    endcase
  end

  // Zero between reads
  always_ff @(posedge pld_avmm_clk or posedge pld_avmm_reset) begin
    if (pld_avmm_reset) begin
      csr_readdata <= '0;
    end else begin
      csr_readdata <= csr_req.read ? read_word : '0;
    end
  end

endmodule

`default_nettype wire

//--- avmm_space_decode.sv
/*
 * Splits Avalon requests between the soft CSR space and the DPRIO space
 * on address bit 11. Gathers the DPRIO block responses and returns the
 * read word of the space that the previous cycle's request addressed.
 */

`timescale 1ns/100ps
`default_nettype none

`include "pll_reconfig_cfg.svh"

module avmm_space_decode (
  input  wire                                   pld_avmm_clk,
  input  wire                                   pld_avmm_reset,
  input  wire pll_reconfig_pkg::avmm_req_t      req,
  output pll_reconfig_pkg::avmm_req_t           csr_req,
  output pll_reconfig_pkg::avmm_req_t           dprio_req,
  input  wire [`AVMM_DATA_W-1:0]                csr_readdata,
  input  wire pll_reconfig_pkg::blk_rsp_t [1:0] blk_rsp,
  output logic [`AVMM_DATA_W-1:0]               readdata
);
  import pll_reconfig_pkg::*;

  // High for soft CSR space
  logic                    csr_sel;
  // Copy of the select from the request cycle
  logic                    csr_sel_q;
  // All block responses ORed together
  blk_rsp_t                rsp_merged;
  logic [`AVMM_DATA_W-1:0] dprio_readdata;

  assign csr_sel = req.address[`CSR_SEL_BIT];

  // CSR side only sees strobes when bit 11 is set
  // Address and data pass through untouched
  always_comb begin
    csr_req       = req;
    csr_req.write = req.write & csr_sel;
    csr_req.read  = req.read & csr_sel;
  end

  // DPRIO side gets the complement
  always_comb begin
    dprio_req       = req;
    dprio_req.write = req.write & ~csr_sel;
    dprio_req.read  = req.read & ~csr_sel;
  end

  // Sampled every cycle, not only on reads
  // Data of both spaces is registered with the same latency,
  // so this copy lines up with the returned word
  always_ff @(posedge pld_avmm_clk or posedge pld_avmm_reset) begin
    if (pld_avmm_reset) begin
      csr_sel_q <= 1'b0;
    end else begin
      csr_sel_q <= csr_sel;
    end
  end

  // At most one block answers a given read
  always_comb begin
    rsp_merged = '0;
    for (int i = 0; i < 2; i++) begin
      rsp_merged.blockselect = rsp_merged.blockselect | blk_rsp[i].blockselect;
      rsp_merged.readdata    = rsp_merged.readdata | blk_rsp[i].readdata;
    end
  end

  // Empty slot reads zero
  assign dprio_readdata = rsp_merged.blockselect ? rsp_merged.readdata : '0;

  // Returned word
  assign readdata = csr_sel_q ? csr_readdata : dprio_readdata;

endmodule

`default_nettype wire

//--- pll_reconfig_top.sv
/*
 * Reconfiguration register access for one transmit PLL. Splits the Avalon
 * bus into soft CSR and DPRIO space and builds the DPRIO blocks that
 * the chosen PLL type fills.
 */

`timescale 1ns/100ps
`default_nettype none

`include "pll_reconfig_cfg.svh"

module pll_reconfig_top #(
  parameter pll_reconfig_pkg::pll_type_e pll_type = pll_reconfig_pkg::CMU
) (
  input  wire                              pld_avmm_clk,
  input  wire                              pld_avmm_reset,
  input  wire pll_reconfig_pkg::avmm_req_t pld_avmm_req,
  output logic [`AVMM_DATA_W-1:0]          pld_avmm_readdata,
  input  wire                              pll_locked,
  output logic                             pll_reset_ovr
);
  import pll_reconfig_pkg::*;

  // Gated requests per space
  avmm_req_t               csr_req;
  avmm_req_t               dprio_req;
  logic [`AVMM_DATA_W-1:0] csr_readdata;
  // One response per DPRIO block
  wire blk_rsp_t [1:0]     blk_rsp;

  // Space split and read data return
  avmm_space_decode space_decode_i (
    .pld_avmm_clk   (pld_avmm_clk),
    .pld_avmm_reset (pld_avmm_reset),
    .req            (pld_avmm_req),
    .csr_req        (csr_req),
    .dprio_req      (dprio_req),
    .csr_readdata   (csr_readdata),
    .blk_rsp        (blk_rsp),
    .readdata       (pld_avmm_readdata)
  );

  // Soft CSR with type, lock status and reset override
  pll_soft_csr #(
    .pll_type (pll_type)
  ) soft_csr_i (
    .pld_avmm_clk   (pld_avmm_clk),
    .pld_avmm_reset (pld_avmm_reset),
    .csr_req        (csr_req),
    .csr_readdata   (csr_readdata),
    .pll_locked     (pll_locked),
    .pll_reset_ovr  (pll_reset_ovr)
  );

  // CMU fills the CDR slot and its refclk mux slot
  if (pll_type == CMU) begin : g_cmu
    dprio_block_regs #(
      .slot (`SLOT_CDR)
    ) cdr_regs_i (
      .pld_avmm_clk   (pld_avmm_clk),
      .pld_avmm_reset (pld_avmm_reset),
      .dprio_req      (dprio_req),
      .rsp            (blk_rsp[0])
    );
    dprio_block_regs #(
      .slot (`SLOT_CDR_MUX)
    ) cdr_mux_regs_i (
      .pld_avmm_clk   (pld_avmm_clk),
      .pld_avmm_reset (pld_avmm_reset),
      .dprio_req      (dprio_req),
      .rsp            (blk_rsp[1])
    );
  // ATX fills the ATX slot and the LC refclk mux slot
  end else if (pll_type == ATX) begin : g_atx
    dprio_block_regs #(
      .slot (`SLOT_ATX)
    ) atx_regs_i (
      .pld_avmm_clk   (pld_avmm_clk),
      .pld_avmm_reset (pld_avmm_reset),
      .dprio_req      (dprio_req),
      .rsp            (blk_rsp[0])
    );
    dprio_block_regs #(
      .slot (`SLOT_ATX_MUX)
    ) atx_mux_regs_i (
      .pld_avmm_clk   (pld_avmm_clk),
      .pld_avmm_reset (pld_avmm_reset),
      .dprio_req      (dprio_req),
      .rsp            (blk_rsp[1])
    );
  end else begin : g_none
    // No PLL so the whole DPRIO space reads zero
    assign blk_rsp = '0;
  end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
/*
 * Testbench clock and reset source. Free-running clock and an active
 * high reset that is released on a falling edge after the hold time.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 16
) (
  output logic pld_avmm_clk,
  output logic pld_avmm_reset
);

  initial pld_avmm_clk = 1'b0;
  always #(period_ns / 2) pld_avmm_clk = ~pld_avmm_clk;

  // Release away from the rising edge
  initial begin
    pld_avmm_reset = 1'b1;
    repeat (reset_cycles) @(posedge pld_avmm_clk);
    @(negedge pld_avmm_clk);
    pld_avmm_reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- tb_pll_reconfig.sv
/*
 * Directed testbench for the TX PLL reconfiguration access, CMU type.
 * Each test task drives the Avalon bus on the falling edge and checks
 * read data one cycle after each read. Ends with a count line.
 */

`timescale 1ns/100ps
`default_nettype none

`include "pll_reconfig_cfg.svh"

module tb_pll_reconfig;
  import pll_reconfig_pkg::*;

  logic                    pld_avmm_clk;
  logic                    pld_avmm_reset;
  avmm_req_t               req;
  logic [`AVMM_DATA_W-1:0] pld_avmm_readdata;
  logic                    pll_locked;
  logic                    pll_reset_ovr;

  integer                  seed = 32'h45ac;
  int                      error_count;
  int                      errors_at_start;
  int                      test_count;
  int                      failed_tests;
  bit                      reset_ok;
  // Words written to the CDR slot [0] and the CDR mux slot [1]
  logic [`AVMM_DATA_W-1:0] exp_regs [2][16];
  // Pending pipelined reads
  logic [`AVMM_ADDR_W-1:0] burst_addr [$];
  logic [`AVMM_DATA_W-1:0] burst_exp [$];

  tb_clock_gen #(
    .period_ns    (40),
    .reset_cycles (16)
  ) clock_gen_i (
    .pld_avmm_clk   (pld_avmm_clk),
    .pld_avmm_reset (pld_avmm_reset)
  );

  pll_reconfig_top #(
    .pll_type (pll_reconfig_pkg::CMU)
  ) dut_i (
    .pld_avmm_clk      (pld_avmm_clk),
    .pld_avmm_reset    (pld_avmm_reset),
    .pld_avmm_req      (req),
    .pld_avmm_readdata (pld_avmm_readdata),
    .pll_locked        (pll_locked),
    .pll_reset_ovr     (pll_reset_ovr)
  );

  // Bit 11 set with the offset below it
  function automatic logic [`AVMM_ADDR_W-1:0] csr_addr(input int offset);
    logic [`AVMM_ADDR_W-1:0] a;
    a = '0;
    a[`CSR_SEL_BIT] = 1'b1;
    a[`CSR_SEL_BIT-1:0] = offset[`CSR_SEL_BIT-1:0];
    return a;
  endfunction

  // Bit 11 clear with the slot in 10:4 and the register in 3:0
  function automatic logic [`AVMM_ADDR_W-1:0] dprio_addr(input int slot, input int idx);
    logic [`AVMM_ADDR_W-1:0] a;
    a = '0;
    a[`CSR_SEL_BIT-1:`DPRIO_SLOT_LSB] = slot[`CSR_SEL_BIT-`DPRIO_SLOT_LSB-1:0];
    a[`DPRIO_REG_W-1:0] = idx[`DPRIO_REG_W-1:0];
    return a;
  endfunction

  function automatic logic [`AVMM_DATA_W-1:0] random_word();
    logic [31:0] r;
    r = $random(seed);
    return r[`AVMM_DATA_W-1:0];
  endfunction

  task automatic check_data(input string name, input logic [`AVMM_DATA_W-1:0] got,
                            input logic [`AVMM_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h, expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h, expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  // Called right after a falling edge; write lands on the next rising edge
  task automatic bus_write(input logic [`AVMM_ADDR_W-1:0] addr,
                           input logic [`AVMM_DATA_W-1:0] data);
    req = '0;
    req.write = 1'b1;
    req.address = addr;
    req.writedata = data;
    @(negedge pld_avmm_clk);
    req = '0;
  endtask

  // Data is sampled one cycle after the read strobe
  task automatic read_expect(input logic [`AVMM_ADDR_W-1:0] addr,
                             input logic [`AVMM_DATA_W-1:0] exp);
    req = '0;
    req.read = 1'b1;
    req.address = addr;
    @(negedge pld_avmm_clk);
    req = '0;
    check_data($sformatf("pld_avmm_readdata at 0x%h", addr), pld_avmm_readdata, exp);
  endtask

  // Back-to-back reads with each answer checked while the next read is driven
  task automatic run_read_burst();
    int n;
    n = burst_addr.size();
    for (int i = 0; i < n; i++) begin
      req = '0;
      req.read = 1'b1;
      req.address = burst_addr[i];
      @(negedge pld_avmm_clk);
      check_data($sformatf("pld_avmm_readdata at 0x%h", burst_addr[i]),
                 pld_avmm_readdata, burst_exp[i]);
    end
    req = '0;
    burst_addr.delete();
    burst_exp.delete();
  endtask

  task automatic report_test(input string name);
    int errs;
    errs = error_count - errors_at_start;
    test_count++;
    if (errs == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: failed with %0d errors", name, errs);
      failed_tests++;
    end
    errors_at_start = error_count;
  endtask

  task automatic reset_defaults();
    read_expect(csr_addr(`CSR_REG_TYPE), 16'h0001);
    check_bit("pll_reset_ovr", pll_reset_ovr, 1'b0);
    read_expect(dprio_addr(`SLOT_CDR, 3), 16'h0000);
    report_test("reset_defaults");
  endtask

  task automatic dprio_readback();
    int slots [2];
    slots[0] = `SLOT_CDR;
    slots[1] = `SLOT_CDR_MUX;
    for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < 16; i++) begin
        exp_regs[s][i] = random_word();
        bus_write(dprio_addr(slots[s], i), exp_regs[s][i]);
      end
    end
    // Single reads first
    for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < 16; i++) begin
        read_expect(dprio_addr(slots[s], i), exp_regs[s][i]);
      end
    end
    // Then all 32 back to back in reverse order
    for (int s = 1; s >= 0; s--) begin
      for (int i = 15; i >= 0; i--) begin
        burst_addr.push_back(dprio_addr(slots[s], i));
        burst_exp.push_back(exp_regs[s][i]);
      end
    end
    run_read_burst();
    report_test("dprio_readback");
  endtask

  task automatic unused_slots_ignored();
    int slots [3];
    slots[0] = `SLOT_ATX;
    slots[1] = `SLOT_ATX_MUX;
    slots[2] = 40;
    for (int s = 0; s < 3; s++) begin
      bus_write(dprio_addr(slots[s], 2), random_word());
      bus_write(dprio_addr(slots[s], 9), random_word());
      read_expect(dprio_addr(slots[s], 2), 16'h0000);
      read_expect(dprio_addr(slots[s], 9), 16'h0000);
    end
    // CSR write whose low bits alias CDR slot register 2
    bus_write(csr_addr((`SLOT_CDR << `DPRIO_SLOT_LSB) + 2), ~exp_regs[0][2]);
    read_expect(csr_addr((`SLOT_CDR << `DPRIO_SLOT_LSB) + 2), 16'h0000);
    // DPRIO write to empty slot 0 whose low bits alias the CSR control offset
    bus_write(dprio_addr(0, `CSR_REG_CTRL), 16'h0001);
    check_bit("pll_reset_ovr", pll_reset_ovr, 1'b0);
    read_expect(csr_addr(`CSR_REG_CTRL), 16'h0000);
    read_expect(dprio_addr(0, `CSR_REG_CTRL), 16'h0000);
    // Same register index in the CMU slots is untouched
    read_expect(dprio_addr(`SLOT_CDR, 2), exp_regs[0][2]);
    read_expect(dprio_addr(`SLOT_CDR_MUX, 9), exp_regs[1][9]);
    report_test("unused_slots_ignored");
  endtask

  task automatic lock_status_sticky();
    read_expect(csr_addr(`CSR_REG_STATUS), 16'h0001);
    // Falling edge of lock is seen at the next rising edge
    pll_locked = 1'b0;
    @(negedge pld_avmm_clk);
    read_expect(csr_addr(`CSR_REG_STATUS), 16'h0002);
    pll_locked = 1'b1;
    @(negedge pld_avmm_clk);
    read_expect(csr_addr(`CSR_REG_STATUS), 16'h0003);
    // Write 1 to clear the sticky bit
    bus_write(csr_addr(`CSR_REG_STATUS), 16'h0002);
    read_expect(csr_addr(`CSR_REG_STATUS), 16'h0001);
    report_test("lock_status_sticky");
  endtask

  task automatic reset_override();
    bus_write(csr_addr(`CSR_REG_CTRL), 16'h0001);
    check_bit("pll_reset_ovr", pll_reset_ovr, 1'b1);
    read_expect(csr_addr(`CSR_REG_CTRL), 16'h0001);
    bus_write(csr_addr(`CSR_REG_CTRL), 16'h0000);
    check_bit("pll_reset_ovr", pll_reset_ovr, 1'b0);
    read_expect(csr_addr(`CSR_REG_CTRL), 16'h0000);
    report_test("reset_override");
  endtask

  task automatic alternating_spaces();
    // CSR and DPRIO reads interleaved without gaps
    burst_addr.push_back(csr_addr(`CSR_REG_TYPE));
    burst_exp.push_back(16'h0001);
    burst_addr.push_back(dprio_addr(`SLOT_CDR, 0));
    burst_exp.push_back(exp_regs[0][0]);
    burst_addr.push_back(csr_addr(`CSR_REG_STATUS));
    burst_exp.push_back(16'h0001);
    burst_addr.push_back(dprio_addr(`SLOT_CDR_MUX, 15));
    burst_exp.push_back(exp_regs[1][15]);
    burst_addr.push_back(csr_addr(`CSR_REG_CTRL));
    burst_exp.push_back(16'h0000);
    burst_addr.push_back(dprio_addr(`SLOT_CDR, 7));
    burst_exp.push_back(exp_regs[0][7]);
    burst_addr.push_back(csr_addr(`CSR_REG_TYPE));
    burst_exp.push_back(16'h0001);
    burst_addr.push_back(dprio_addr(`SLOT_CDR_MUX, 4));
    burst_exp.push_back(exp_regs[1][4]);
    run_read_burst();
    report_test("alternating_spaces");
  endtask

  // Reset only changes on falling edges, so it is looked at on rising edges
  task automatic wait_reset_release(output bit ok);
    int cycles;
    cycles = 0;
    @(posedge pld_avmm_clk);
    while (pld_avmm_reset && cycles < 40) begin
      @(posedge pld_avmm_clk);
      cycles++;
    end
    ok = !pld_avmm_reset;
  endtask

  initial begin
    req = '0;
    pll_locked = 1'b1;
    error_count = 0;
    errors_at_start = 0;
    test_count = 0;
    failed_tests = 0;
    wait_reset_release(reset_ok);
    if (!reset_ok) begin
      $display("Timeout: reset was never released");
      $display("RESULT: FAIL");
      $finish;
    end else begin
      @(negedge pld_avmm_clk);
      reset_defaults();
      dprio_readback();
      unused_slots_ignored();
      lock_status_sticky();
      reset_override();
      alternating_spaces();
      $display("Tests run %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
      if (error_count == 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
pll_reconfig_pkg.sv
dprio_block_regs.sv
pll_soft_csr.sv
avmm_space_decode.sv
pll_reconfig_top.sv
tb_clock_gen.sv
tb_pll_reconfig.sv

//--- run.sh
#!/bin/sh
# Builds the PLL reconfiguration testbench with Verilator and runs it.
# The exit status follows the result line in the simulation log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
  --top-module tb_pll_reconfig \
  -f list.f

./obj_dir/Vtb_pll_reconfig > sim.log
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
